//--- all.f
+incdir+rtl
rtl/sma_pkg.sv
rtl/sma_apb_regs.sv
rtl/sma_window.sv
rtl/sma_crossover.sv
rtl/sma_trend_top.sv
test/sma_trend_assertions.sv
test/sma_trend_tb.sv

//--- Bender.yml
package:
  name: sma_trend

export_include_dirs:
  - rtl

sources:
  - files:
      - rtl/sma_pkg.sv
      - rtl/sma_apb_regs.sv
      - rtl/sma_window.sv
      - rtl/sma_crossover.sv
      - rtl/sma_trend_top.sv
  - target: test
    files:
      - test/sma_trend_assertions.sv
      - test/sma_trend_tb.sv

//--- test/sma_trend_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "sma_config.svh"

module sma_trend_tb
	import sma_pkg::*;
();

	localparam int PREADY_LIMIT = 16;
	localparam int PHASES       = 14;
	localparam int HIST         = `SMA_DEPTH;

	logic        clk;
	logic        rst_n;
	logic        psel;
	logic        penable;
	logic        pwrite;
	logic [3:0]  paddr;
	logic [31:0] pwdata;
	logic [31:0] prdata;
	logic        pready;
	logic        pslverr;
	sample_t     sample;
	logic        sample_valid;
	avg_t        fast_avg;
	avg_t        slow_avg;
	diff_t       diff;
	logic        valid;
	logic        cross_up;
	logic        cross_dn;

	// reference model with index 0 for the fast channel and 1 for the slow one
	sample_t     hist [2][HIST];
	int          fill [2];
	int          wr_pos [2];
	win_code_t   code [2];
	logic        prev_pos;
	logic [15:0] cross_count;
	logic        cross_dir;

	// expected results in flight where entry 2 is due at the current falling edge
	logic        exp_v [3];
	avg_t        exp_fast [3];
	avg_t        exp_slow [3];
	diff_t       exp_diff [3];
	logic        exp_up [3];
	logic        exp_dn [3];

	int          err_count;
	int          check_count;

	sma_trend_top dut_i (
		.i_clk          (clk),
		.i_rst_n        (rst_n),
		.i_psel         (psel),
		.i_penable      (penable),
		.i_pwrite       (pwrite),
		.i_paddr        (paddr),
		.i_pwdata       (pwdata),
		.o_prdata       (prdata),
		.o_pready       (pready),
		.o_pslverr      (pslverr),
		.i_sample       (sample),
		.i_sample_valid (sample_valid),
		.o_fast_avg     (fast_avg),
		.o_slow_avg     (slow_avg),
		.o_diff         (diff),
		.o_valid        (valid),
		.o_cross_up     (cross_up),
		.o_cross_dn     (cross_dn)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// plain sum of the newest samples since the last flush followed by the shift divide
	function automatic avg_t window_avg(input int ch);
		int n;
		int total;
		n = 1 << code[ch];
		if (fill[ch] < n) begin
			n = fill[ch];
		end
		total = 0;
		for (int k = 0; k < n; k++) begin
			total += hist[ch][(wr_pos[ch] - 1 - k + HIST) % HIST];
		end
		return avg_t'(total >>> code[ch]);
	endfunction

	function automatic void model_push(input sample_t s);
		diff_t d;
		logic  pos;
		for (int ch = 0; ch < 2; ch++) begin
			hist[ch][wr_pos[ch]] = s;
			wr_pos[ch] = (wr_pos[ch] + 1) % HIST;
			if (fill[ch] < HIST) begin
				fill[ch]++;
			end
		end
		exp_fast[0] = window_avg(0);
		exp_slow[0] = window_avg(1);
		d = diff_t'(exp_fast[0]) - diff_t'(exp_slow[0]);
		// zero counts as the lower side
		pos = (d > 0);
		exp_up[0] = !prev_pos && pos;
		exp_dn[0] = prev_pos && !pos;
		if (exp_up[0] || exp_dn[0]) begin
			cross_count++;
			cross_dir = exp_up[0];
		end
		prev_pos    = pos;
		exp_diff[0] = d;
		exp_v[0]    = 1'b1;
	endfunction

	// a legal CTRL write clears the history of each channel whose code moves
	function automatic void model_ctrl_write(input logic [31:0] data);
		win_code_t f;
		win_code_t s;
		f = data[3:0];
		s = data[11:8];
		if (f <= `SMA_MAX_LOG2 && s <= `SMA_MAX_LOG2) begin
			if (f != code[0]) begin
				fill[0] = 0;
			end
			if (s != code[1]) begin
				fill[1] = 0;
			end
			code[0] = f;
			code[1] = s;
		end
	endfunction

	task automatic compare_hex(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		check_count++;
		if (got !== exp) begin
			err_count++;
			$display("MISMATCH %s got %h expected %h at %0t", name, got, exp, $time);
		end
	endtask

	task automatic check_outputs();
		compare_hex("o_valid", valid, exp_v[2]);
		compare_hex("o_cross_up", cross_up, exp_up[2]);
		compare_hex("o_cross_dn", cross_dn, exp_dn[2]);
		if (exp_v[2]) begin
			compare_hex("o_fast_avg", fast_avg, exp_fast[2]);
			compare_hex("o_slow_avg", slow_avg, exp_slow[2]);
			compare_hex("o_diff", diff, exp_diff[2]);
		end
	endtask

	// one falling edge that checks what is due, ages the queue and drives the next sample
	task automatic tick(input logic v, input sample_t s);
		@(negedge clk);
		check_outputs();
		for (int k = 2; k > 0; k--) begin
			exp_v[k]    = exp_v[k-1];
			exp_fast[k] = exp_fast[k-1];
			exp_slow[k] = exp_slow[k-1];
			exp_diff[k] = exp_diff[k-1];
			exp_up[k]   = exp_up[k-1];
			exp_dn[k]   = exp_dn[k-1];
		end
		exp_v[0]     = 1'b0;
		exp_up[0]    = 1'b0;
		exp_dn[0]    = 1'b0;
		sample_valid = v;
		sample       = s;
		if (v) begin
			model_push(s);
		end
	endtask

	task automatic idle(input int cycles);
		repeat (cycles) tick(1'b0, '0);
	endtask

	task automatic run_samples(input int cycles);
		logic    v;
		sample_t s;
		for (int n = 0; n < cycles; n++) begin
			// about 70% of cycles carry a sample
			v = ($urandom % 100) < 70;
			s = sample_t'($urandom);
			tick(v, s);
		end
	endtask

	// setup phase and then access phase until o_pready while samples stay idle
	task automatic apb_xfer(input logic write, input logic [3:0] addr,
		input logic [31:0] wdata, output logic [31:0] rdata, output logic err);
		int waited;
		tick(1'b0, '0);
		psel    = 1'b1;
		penable = 1'b0;
		pwrite  = write;
		paddr   = addr;
		pwdata  = wdata;
		tick(1'b0, '0);
		penable = 1'b1;
		waited  = 0;
		#1;
		while (pready !== 1'b1 && waited < PREADY_LIMIT) begin
			tick(1'b0, '0);
			waited++;
			#1;
		end
		if (pready !== 1'b1) begin
			$display("timeout: o_pready stayed low for %0d cycles of an APB access", waited);
			$display("Test FAILED");
			$finish;
		end else begin
			rdata = prdata;
			err   = pslverr;
			tick(1'b0, '0);
			psel    = 1'b0;
			penable = 1'b0;
			pwrite  = 1'b0;
		end
	endtask

	task automatic read_ctrl_check();
		logic [31:0] rd;
		logic        err;
		apb_xfer(1'b0, `SMA_CTRL_ADDR, '0, rd, err);
		compare_hex("o_pslverr", err, 1'b0);
		compare_hex("o_prdata CTRL", rd, {20'h0, code[1], 4'h0, code[0]});
	endtask

	task automatic check_status();
		logic [31:0] rd;
		logic        err;
		apb_xfer(1'b0, `SMA_STAT_ADDR, '0, rd, err);
		compare_hex("o_pslverr", err, 1'b0);
		compare_hex("o_prdata STAT", rd, {15'h0, cross_dir, cross_count});
	endtask

	task automatic write_ctrl(input logic [31:0] data);
		logic [31:0] rd;
		logic        err;
		logic        exp_err;
		exp_err = (data[3:0] > `SMA_MAX_LOG2) || (data[11:8] > `SMA_MAX_LOG2);
		apb_xfer(1'b1, `SMA_CTRL_ADDR, data, rd, err);
		compare_hex("o_pslverr", err, exp_err);
		model_ctrl_write(data);
		// let the flush pulse pass before the next sample
		idle(2);
		read_ctrl_check();
	endtask

	initial begin
		win_code_t   f;
		win_code_t   s;
		logic [31:0] rd;
		logic        err;
		rst_n        = 1'b0;
		psel         = 1'b0;
		penable      = 1'b0;
		pwrite       = 1'b0;
		paddr        = '0;
		pwdata       = '0;
		sample       = '0;
		sample_valid = 1'b0;
		err_count    = 0;
		check_count  = 0;
		for (int ch = 0; ch < 2; ch++) begin
			fill[ch]   = 0;
			wr_pos[ch] = 0;
		end
		code[0]     = `SMA_FAST_RST;
		code[1]     = `SMA_SLOW_RST;
		prev_pos    = 1'b0;
		cross_count = '0;
		cross_dir   = 1'b0;
		for (int k = 0; k < 3; k++) begin
			exp_v[k]  = 1'b0;
			exp_up[k] = 1'b0;
			exp_dn[k] = 1'b0;
		end
		void'($urandom(32'h9f70));

		repeat (3) @(negedge clk);
		rst_n = 1'b1;

		// quiet outputs and reset codes
		tick(1'b0, '0);
		compare_hex("o_pslverr", pslverr, 1'b0);
		read_ctrl_check();
		check_status();

		// reset windows including the partial fill
		run_samples(400);
		idle(4);
		check_status();

		// sweep both codes over 0..8 and then move one code while the other stays
		for (int ph = 0; ph < PHASES; ph++) begin
			if (ph < 9) begin
				f = ph;
				s = 8 - ph;
			end else if (ph % 2) begin
				f = code[0];
				s = win_code_t'((code[1] + 1 + $urandom % 8) % 9);
			end else begin
				f = win_code_t'((code[0] + 1 + $urandom % 8) % 9);
				s = code[1];
			end
			write_ctrl({20'h0, s, 4'h0, f});
			run_samples(300 + $urandom % 300);
			idle(4);
			check_status();
		end

		// error responses leave the codes alone and issue no flush
		write_ctrl({20'h0, code[1], 4'h0, 4'h9});
		write_ctrl({20'h0, 4'hf, 4'h0, code[0]});
		apb_xfer(1'b1, `SMA_STAT_ADDR, 32'h0001_ffff, rd, err);
		compare_hex("o_pslverr", err, 1'b1);
		apb_xfer(1'b0, 4'h8, '0, rd, err);
		compare_hex("o_pslverr", err, 1'b1);
		read_ctrl_check();
		run_samples(300);
		idle(4);
		check_status();

		err_count += dut_i.cross_i.checks_i.fail_count;
		$display("%0d checks, %0d errors", check_count, err_count);
		if (err_count == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- test/sma_trend_assertions.sv
`timescale 1ns/10ps
`default_nettype none

module sma_trend_assertions (
	input wire i_clk,
	input wire i_rst_n,
	input wire i_fast_valid,
	input wire i_slow_valid,
	input wire i_valid,
	input wire i_cross_up,
	input wire i_cross_dn
);

	// failures so far, the testbench adds them to its error count
	int unsigned fail_count = 0;

	// both channels see every sample with the same latency
	valid_aligned: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		i_fast_valid == i_slow_valid)
	else begin
		$error("fast and slow average valids differ");
		fail_count++;
	end

	// one direction per result
	cross_exclusive: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		!(i_cross_up && i_cross_dn))
	else begin
		$error("up and down crossing pulses high together");
		fail_count++;
	end

	// a crossing pulse only comes with a result
	cross_with_valid: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		(i_cross_up || i_cross_dn) |-> i_valid)
	else begin
		$error("crossing pulse without o_valid");
		fail_count++;
	end

endmodule

bind sma_crossover sma_trend_assertions checks_i (
	.i_clk        (i_clk),
	.i_rst_n      (i_rst_n),
	.i_fast_valid (i_fast_valid),
	.i_slow_valid (i_slow_valid),
	.i_valid      (o_valid),
	.i_cross_up   (o_cross_up),
	.i_cross_dn   (o_cross_dn)
);

`default_nettype wire

//--- rtl/sma_trend_top.sv
`timescale 1ns/10ps
`default_nettype none

module sma_trend_top
	import sma_pkg::*;
(
	input  wire             i_clk,
	input  wire             i_rst_n,
	// APB
	input  wire             i_psel,
	input  wire             i_penable,
	input  wire             i_pwrite,
	input  wire  [3:0]      i_paddr,
	input  wire  [31:0]     i_pwdata,
	output logic [31:0]     o_prdata,
	output logic            o_pready,
	output logic            o_pslverr,
	// sample stream, no back-pressure
	input  wire sample_t    i_sample,
	input  wire             i_sample_valid,
	// results, 3 cycles after each sample
	output avg_t            o_fast_avg,
	output avg_t            o_slow_avg,
	output diff_t           o_diff,
	output logic            o_valid,
	output logic            o_cross_up,
	output logic            o_cross_dn
);

	win_code_t   fast_code;
	win_code_t   slow_code;
	logic        fast_flush;
	logic        slow_flush;
	avg_t        fast_avg;
	avg_t        slow_avg;
	logic        fast_avg_valid;
	logic        slow_avg_valid;
	logic [15:0] cross_count;
	logic        cross_dir;

	sma_apb_regs regs_i (
		.i_clk         (i_clk),
		.i_rst_n       (i_rst_n),
		.i_psel        (i_psel),
		.i_penable     (i_penable),
		.i_pwrite      (i_pwrite),
		.i_paddr       (i_paddr),
		.i_pwdata      (i_pwdata),
		.o_prdata      (o_prdata),
		.o_pready      (o_pready),
		.o_pslverr     (o_pslverr),
		.i_cross_count (cross_count),
		.i_cross_dir   (cross_dir),
		.o_fast_code   (fast_code),
		.o_slow_code   (slow_code),
		.o_fast_flush  (fast_flush),
		.o_slow_flush  (slow_flush)
	);

	// short window
	sma_window fast_i (
		.i_clk          (i_clk),
		.i_rst_n        (i_rst_n),
		.i_sample_valid (i_sample_valid),
		.i_sample       (i_sample),
		.i_code         (fast_code),
		.i_flush        (fast_flush),
		.o_avg          (fast_avg),
		.o_avg_valid    (fast_avg_valid)
	);

	// long window
	sma_window slow_i (
		.i_clk          (i_clk),
		.i_rst_n        (i_rst_n),
		.i_sample_valid (i_sample_valid),
		.i_sample       (i_sample),
		.i_code         (slow_code),
		.i_flush        (slow_flush),
		.o_avg          (slow_avg),
		.o_avg_valid    (slow_avg_valid)
	);

	sma_crossover cross_i (
		.i_clk         (i_clk),
		.i_rst_n       (i_rst_n),
		.i_fast_avg    (fast_avg),
		.i_slow_avg    (slow_avg),
		.i_fast_valid  (fast_avg_valid),
		.i_slow_valid  (slow_avg_valid),
		.o_fast_avg    (o_fast_avg),
		.o_slow_avg    (o_slow_avg),
		.o_diff        (o_diff),
		.o_valid       (o_valid),
		.o_cross_up    (o_cross_up),
		.o_cross_dn    (o_cross_dn),
		.o_cross_count (cross_count),
		.o_cross_dir   (cross_dir)
	);

endmodule

`default_nettype wire

//--- rtl/sma_crossover.sv
`timescale 1ns/10ps
`default_nettype none

module sma_crossover
	import sma_pkg::*;
(
	input  wire          i_clk,
	input  wire          i_rst_n,
	input  wire avg_t    i_fast_avg,
	input  wire avg_t    i_slow_avg,
	input  wire          i_fast_valid,
	input  wire          i_slow_valid,
	output avg_t         o_fast_avg,
	output avg_t         o_slow_avg,
	output diff_t        o_diff,
	output logic         o_valid,
	output logic         o_cross_up,
	output logic         o_cross_dn,
	output logic [15:0]  o_cross_count,
	output logic         o_cross_dir
);

	logic  both;
	diff_t diff_nxt;
	logic  new_pos;
	logic  prev_pos;
	logic  up;
	logic  dn;

	// both channels run in lockstep on the same samples
	assign both = i_fast_valid & i_slow_valid;

	assign diff_nxt = diff_t'(i_fast_avg) - diff_t'(i_slow_avg);

	// strictly above zero, zero belongs to the lower side
	assign new_pos = ~diff_nxt[$bits(diff_t)-1] & (diff_nxt != '0);

	assign up = both & ~prev_pos & new_pos;
	assign dn = both & prev_pos & ~new_pos;

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_valid       <= 1'b0;
			o_cross_up    <= 1'b0;
			o_cross_dn    <= 1'b0;
			// previous difference starts as zero, so not positive
			prev_pos      <= 1'b0;
			o_cross_count <= '0;
			o_cross_dir   <= 1'b0;
		end else begin
			o_valid    <= both;
			o_cross_up <= up;
			o_cross_dn <= dn;
			if (both) begin
				prev_pos <= new_pos;
			end
			// counter wraps at 16 bits
			if (up | dn) begin
				o_cross_count <= o_cross_count + 1'b1;
				o_cross_dir   <= up;
			end
		end
	end

	always_ff @(posedge i_clk) begin
		if (both) begin
			o_fast_avg <= i_fast_avg;
			o_slow_avg <= i_slow_avg;
			o_diff     <= diff_nxt;
		end
	end

endmodule

`default_nettype wire

//--- rtl/sma_window.sv
`timescale 1ns/10ps
`default_nettype none

`include "sma_config.svh"

module sma_window
	import sma_pkg::*;
(
	input  wire             i_clk,
	input  wire             i_rst_n,
	input  wire             i_sample_valid,
	input  wire sample_t    i_sample,
	input  wire win_code_t  i_code,
	input  wire             i_flush,
	output avg_t            o_avg,
	output logic            o_avg_valid
);

	localparam int PTR_W = `SMA_MAX_LOG2;
	localparam int DEPTH = `SMA_DEPTH;

	// circular history of the last DEPTH samples
	sample_t          mem [DEPTH];

	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [PTR_W:0]   win_len;
	logic [PTR_W:0]   fill;
	logic             full;

	// stage 1 registers
	logic             s1_valid;
	sample_t          s1_sample;
	sample_t          s1_prev;
	sample_t          s1_mem;
	logic [PTR_W-1:0] s1_ptr;
	logic             s1_fwd;
	logic             s1_use;

	// stage 2 arithmetic
	sample_t          old_sample;
	sum_t             sum_q;
	sum_t             sum_nxt;
	sum_t             sum_sh;

	// 1, 2, 4 .. 256
	assign win_len = {{PTR_W{1'b0}}, 1'b1} << i_code;

	// slot of the sample that leaves the window
	// for 256 the low bits are zero and rd_ptr wraps onto wr_ptr
	assign rd_ptr = wr_ptr - win_len[PTR_W-1:0];

	// window holds a full set of samples since the last flush
	assign full = (fill == win_len);

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			wr_ptr      <= '0;
			fill        <= '0;
			s1_valid    <= 1'b0;
			o_avg_valid <= 1'b0;
			sum_q       <= '0;
		end else begin
			s1_valid    <= i_sample_valid;
			o_avg_valid <= s1_valid;
			if (i_sample_valid) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			// flush forgets the history, missing samples then count as zero
			if (i_flush) begin
				fill <= '0;
			end else if (i_sample_valid && !full) begin
				fill <= fill + 1'b1;
			end
			if (i_flush) begin
				sum_q <= '0;
			end else if (s1_valid) begin
				sum_q <= sum_nxt;
			end
		end
	end

	// stage 1, fetch the leaving sample
	always_ff @(posedge i_clk) begin
		if (i_sample_valid) begin
			s1_sample <= i_sample;
			s1_prev   <= s1_sample;
			s1_ptr    <= wr_ptr;
			s1_mem    <= mem[rd_ptr];
			// window 1 back to back wants the sample stage 2 writes on this edge
			s1_fwd    <= s1_valid && (rd_ptr == s1_ptr);
			s1_use    <= full;
		end
	end

	// history write happens in stage 2
	always_ff @(posedge i_clk) begin
		if (s1_valid) begin
			mem[s1_ptr] <= s1_sample;
		end
	end

	always_comb begin
		if (!s1_use) begin
			old_sample = '0;
		end else if (s1_fwd) begin
			old_sample = s1_prev;
		end else begin
			old_sample = s1_mem;
		end
	end

	// add the newest, drop the oldest
	assign sum_nxt = sum_q + sum_t'(s1_sample) - sum_t'(old_sample);

	// arithmetic shift is the divide, no rounding
	assign sum_sh = sum_nxt >>> i_code;

	always_ff @(posedge i_clk) begin
		if (s1_valid) begin
			o_avg <= sum_sh[`SMA_SAMPLE_W-1:0];
		end
	end

endmodule

`default_nettype wire

//--- rtl/sma_apb_regs.sv
`timescale 1ns/10ps
`default_nettype none

`include "sma_config.svh"

module sma_apb_regs
	import sma_pkg::*;
(
	input  wire             i_clk,
	input  wire             i_rst_n,
	// APB slave side
	input  wire             i_psel,
	input  wire             i_penable,
	input  wire             i_pwrite,
	input  wire  [3:0]      i_paddr,
	input  wire  [31:0]     i_pwdata,
	output logic [31:0]     o_prdata,
	output logic            o_pready,
	output logic            o_pslverr,
	// status from the crossover
	input  wire  [15:0]     i_cross_count,
	input  wire             i_cross_dir,
	// window control to the channels
	output win_code_t       o_fast_code,
	output win_code_t       o_slow_code,
	output logic            o_fast_flush,
	output logic            o_slow_flush
);

	logic      access;
	logic      addr_ctrl;
	logic      addr_stat;
	win_code_t wr_fast;
	win_code_t wr_slow;
	logic      code_bad;
	logic      wr_err;
	logic      map_err;
	logic      ctrl_wr;

	// access phase of a transfer, setup phase is just psel alone
	assign access = i_psel & i_penable;

	assign addr_ctrl = (i_paddr == `SMA_CTRL_ADDR);
	assign addr_stat = (i_paddr == `SMA_STAT_ADDR);

	// code fields of a CTRL write
	assign wr_fast = i_pwdata[3:0];
	assign wr_slow = i_pwdata[11:8];

	// windows above 256 samples do not exist
	assign code_bad = (wr_fast > win_code_t'(`SMA_MAX_LOG2)) |
		(wr_slow > win_code_t'(`SMA_MAX_LOG2));

	// STAT is read-only, CTRL rejects bad codes as a whole
	assign wr_err  = i_pwrite & (addr_stat | (addr_ctrl & code_bad));
	assign map_err = ~addr_ctrl & ~addr_stat;

	// no wait states
	assign o_pready  = 1'b1;
	assign o_pslverr = access & (wr_err | map_err);

	// only a clean CTRL write updates the codes
	assign ctrl_wr = access & i_pwrite & addr_ctrl & ~code_bad;

	// read mux, unused bits read as zero
	always_comb begin
		o_prdata = '0;
		if (addr_ctrl) begin
			o_prdata[3:0]  = o_fast_code;
			o_prdata[11:8] = o_slow_code;
		end else if (addr_stat) begin
			o_prdata[15:0] = i_cross_count;
			o_prdata[16]   = i_cross_dir;
		end
	end

	// codes and flush pulses land on the same edge
	// so a channel sees its new code in the flush cycle
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_fast_code  <= `SMA_FAST_RST;
			o_slow_code  <= `SMA_SLOW_RST;
			o_fast_flush <= 1'b0;
			o_slow_flush <= 1'b0;
		end else begin
			// rewriting the same code keeps the channel history
			o_fast_flush <= ctrl_wr & (wr_fast != o_fast_code);
			o_slow_flush <= ctrl_wr & (wr_slow != o_slow_code);
			if (ctrl_wr) begin
				o_fast_code <= wr_fast;
				o_slow_code <= wr_slow;
			end
		end
	end

endmodule

`default_nettype wire

//--- rtl/sma_pkg.sv
`default_nettype none

`include "sma_config.svh"

package sma_pkg;

	// one signed input sample
	typedef logic signed [`SMA_SAMPLE_W-1:0] sample_t;

	// running sum, wide enough for a full window of worst-case samples
	typedef logic signed [`SMA_SAMPLE_W+`SMA_MAX_LOG2-1:0] sum_t;

	// average after the shift divide, same range as a sample
	typedef logic signed [`SMA_SAMPLE_W-1:0] avg_t;

	// fast minus slow, one extra bit so it never wraps
	typedef logic signed [`SMA_SAMPLE_W:0] diff_t;

	// log2 of the window length, 0..8 are legal
	typedef logic [3:0] win_code_t;

endpackage

`default_nettype wire

//--- rtl/sma_config.svh
`ifndef SMA_CONFIG_SVH
`define SMA_CONFIG_SVH

// width of one input sample
`define SMA_SAMPLE_W 16

// largest window is 2**8 samples
`define SMA_MAX_LOG2 8

// sample memory depth, one entry per sample of the largest window
`define SMA_DEPTH (1 << `SMA_MAX_LOG2)

// APB register offsets
`define SMA_CTRL_ADDR 4'h0
`define SMA_STAT_ADDR 4'h4

// window codes loaded at reset
// fast channel averages 4 samples, slow channel 32
`define SMA_FAST_RST 4'd2
`define SMA_SLOW_RST 4'd5

`endif
